// ==== dv/scoreboard_testdata.txt ====
# P inning half action  (half 0 top, 1 bottom; action 0 walk .. 7 fly ball)
# G name score_a score_b result  (result 0 guest win, 1 home win, 2 draw)
P 1 0 4
P 1 0 3
P 1 0 4
P 1 1 4
G scoring_by_half 3 1 0
P 1 0 0
P 1 0 0
P 1 0 0
P 1 0 0
P 1 0 7
P 1 0 7
P 1 0 1
P 1 0 7
G forced_advance 3 0 0
P 1 0 1
P 1 0 6
P 1 0 0
P 1 0 0
P 1 0 0
P 1 0 5
P 1 1 2
P 1 1 1
P 1 1 3
P 1 1 7
G retire_side 0 3 1
P 2 0 0
P 2 0 0
P 2 0 3
P 2 0 0
P 2 0 7
P 2 0 1
P 2 0 7
P 2 0 2
G fly_ball 5 0 0
P 2 1 4
P 3 0 5
P 3 0 5
P 3 0 5
P 3 1 4
G skipped_bottom 0 1 1
P 1 0 4
P 1 1 4
P 3 0 7
P 3 0 7
P 3 0 7
G draw_game 1 1 2
P 1 0 4
P 1 1 4
P 1 1 4
G restart 1 2 1

// ==== scoreboard.f ====
+incdir+hdl
hdl/scoreboard_pkg.sv
hdl/base_runner.sv
hdl/score_keeper.sv
hdl/scoreboard.sv
dv/scoreboard_sva.sv
dv/scoreboard_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= scoreboard_tb
RTL_TOP   ?= scoreboard
FILELIST  ?= scoreboard.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/scoreboard_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard_tb import scoreboard_pkg::*; ();

    typedef logic [8*24-1:0] name_t;

    localparam string DATA_FILE = "dv/scoreboard_testdata.txt";

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [1:0] inning;
    logic       half;
    action_t    action;
    logic       out_valid;
    score_t     score_a;
    score_t     score_b;
    result_t    result;

    int    play_inning[$];
    int    play_half[$];
    int    play_action[$];
    int    game_last[$];   // One past the game's final play
    name_t game_name[$];
    int    exp_a[$];
    int    exp_b[$];
    int    exp_res[$];

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int pulses = 0;
    int cycles = 0;
    int cycle_limit = 1000;

    scoreboard DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inning    (inning),
        .half      (half),
        .action    (action),
        .out_valid (out_valid),
        .score_a   (score_a),
        .score_b   (score_b),
        .result    (result)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout, run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) pulses <= pulses + 1;  // One per final report
    end

    task automatic check_score(input name_t test, input string what, input score_t expected,
                               input score_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %0s %0s expected %0d actual %0d",
                     test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_result(input name_t test, input result_t expected,
                                input result_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %0s result expected %0d actual %0d", test, expected, actual);
            errors++;
        end
    endtask

    task automatic load_tests(output bit ok);
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        string line;
        name_t name;
        ok = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "P") begin
                    n = $sscanf(line, "P %d %d %d", a, b, c);
                    play_inning.push_back(a);
                    play_half.push_back(b);
                    play_action.push_back(c);
                end else if (n > 0 && line.getc(0) == "G") begin
                    n = $sscanf(line, "G %s %d %d %d", name, a, b, c);
                    game_last.push_back(play_inning.size());
                    game_name.push_back(name);
                    exp_a.push_back(a);
                    exp_b.push_back(b);
                    exp_res.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int first;
        int gap;
        int waited;
        int errors_before;
        bit ok;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        inning   = 2'd0;
        half     = 1'b0;
        action   = ACT_WALK;
        gap      = $urandom(32'h7bde_bdb0);
        load_tests(ok);
        cycle_limit = 2 * play_inning.size() + 10 * game_name.size();
        if (!ok) begin
            $display("Test data file %0s could not be opened", DATA_FILE);
            errors++;
        end else begin
            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            first = 0;
            foreach (game_name[g]) begin
                errors_before = errors;
                for (int i = first; i < game_last[g]; i++) begin
                    @(posedge clk);
                    in_valid <= 1'b1;
                    inning   <= 2'(play_inning[i]);
                    half     <= (play_half[i] != 0);
                    action   <= action_t'(play_action[i]);
                end
                @(posedge clk);
                in_valid <= 1'b0;  // Ends the game
                waited = 0;
                @(negedge clk);
                while (!out_valid && waited < 4) begin
                    @(negedge clk);
                    waited++;
                end
                if (!out_valid) begin
                    $display("No out_valid pulse after game %0s", game_name[g]);
                    errors++;
                end else begin
                    check_score(game_name[g], "score_a", score_t'(exp_a[g]), score_a);
                    check_score(game_name[g], "score_b", score_t'(exp_b[g]), score_b);
                    check_result(game_name[g], result_t'(exp_res[g]), result);
                end
                if (errors == errors_before) begin
                    passed++;
                    $display("PASS %0s", game_name[g]);
                end else begin
                    failed++;
                    $display("FAIL %0s", game_name[g]);
                end
                gap = $urandom_range(3, 1);  // Idle cycles between games
                repeat (gap) @(posedge clk);
                first = game_last[g];
            end
            if (pulses != game_name.size()) begin
                $display("Saw %0d out_valid pulses for %0d games", pulses, game_name.size());
                errors++;
            end
            if (DUT.u_sva.failures != 0) begin
                $display("%0d assertion failures during the run", DUT.u_sva.failures);
                errors += DUT.u_sva.failures;
            end
        end
        $display("Games %0d, passed %0d, failed %0d, errors %0d",
                 game_name.size(), passed, failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/scoreboard_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard_sva import scoreboard_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    in_valid,
    input logic    out_valid,
    input score_t  score_a,
    input score_t  score_b,
    input result_t result
);

    int failures = 0;

    // Final report lasts one cycle
    a_pulse_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high for more than one cycle");
            failures++;
        end

    a_pulse_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !in_valid)
        else begin
            $error("out_valid while a play is presented");
            failures++;
        end

    // Reported winner agrees with the final scores
    a_result_legal: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ((result == RES_GUEST_WIN && score_a > score_b) ||
                       (result == RES_HOME_WIN && score_b > score_a) ||
                       (result == RES_DRAW && score_a == score_b)))
        else begin
            $error("result does not match the final scores");
            failures++;
        end

    a_scores_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ($stable(score_a) && $stable(score_b)))
        else begin
            $error("score changed during the final report");
            failures++;
        end

endmodule

bind scoreboard scoreboard_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .score_a   (score_a),
    .score_b   (score_b),
    .result    (result)
);

`default_nettype wire

// ==== hdl/scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard import scoreboard_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic [1:0] inning,
    input  logic       half,
    input  action_t    action,
    output logic       out_valid,
    output score_t     score_a,
    output score_t     score_b,
    output result_t    result
);

    play_result_t play;  // Same cycle as the play

    base_runner u_base_runner (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .action   (action),
        .play     (play)
    );

    score_keeper u_score_keeper (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inning    (inning),
        .half      (half),
        .play      (play),
        .out_valid (out_valid),
        .score_a   (score_a),
        .score_b   (score_b),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== hdl/score_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scoreboard_settings.svh"

module score_keeper import scoreboard_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  logic [1:0]   inning,
    input  logic         half,
    input  play_result_t play,
    output logic         out_valid,
    output score_t       score_a,
    output score_t       score_b,
    output result_t      result
);

    logic    game_active;
    logic    frozen;
    logic    first_play;
    logic    frozen_eff;
    logic    freeze_now;
    logic    game_end;
    score_t  base_a;
    score_t  base_b;
    score_t  runs_a;
    score_t  runs_b;
    result_t winner;

    assign first_play = in_valid && !game_active;
    assign game_end   = game_active && !in_valid;

    // A new game starts from zero
    assign base_a     = first_play ? score_t'(0) : score_a;
    assign base_b     = first_play ? score_t'(0) : score_b;
    assign frozen_eff = frozen && !first_play;

    assign runs_a = half ? score_t'(0) : score_t'(play.runs);
    assign runs_b = half ? score_t'(play.runs) : score_t'(0);

    // Home team leads after the top of the last inning
    assign freeze_now = play.valid && play.side_retired && !half &&
                        (inning == 2'(`SB_LAST_INNING)) && (base_b > base_a);

    always_comb begin
        if (score_a > score_b) begin
            winner = RES_GUEST_WIN;
        end else if (score_a < score_b) begin
            winner = RES_HOME_WIN;
        end else begin
            winner = RES_DRAW;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_active <= 1'b0;
            frozen      <= 1'b0;
            out_valid   <= 1'b0;
            result      <= RES_GUEST_WIN;
            score_a     <= '0;
            score_b     <= '0;
        end else begin
            game_active <= in_valid;
            out_valid   <= game_end;
            result      <= game_end ? winner : RES_GUEST_WIN;
            if (play.valid) begin
                frozen <= frozen_eff || freeze_now;
                if (!frozen_eff) begin
                    score_a <= base_a + runs_a;
                    score_b <= base_b + runs_b;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/base_runner.sv ====
`timescale 1ns/1ps
`default_nettype none

module base_runner import scoreboard_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  action_t      action,
    output play_result_t play
);

    bases_t     bases;
    outs_t      outs;
    logic       two_outs;
    logic [6:0] adv;         // {runners home, next bases}
    outs_t      outs_add;
    logic [2:0] outs_total;
    logic       retire;
    runs_t      runs;

    // Moves every set bit of {third, second, first, batter} up by k bases
    function automatic logic [6:0] advance(input logic [3:0] v, input logic [2:0] k);
        logic [7:0] w;
        w = {4'b0000, v} << k;
        return w[7:1];
    endfunction

    function automatic runs_t count_runs(input logic [3:0] home);
        runs_t n;
        n = '0;
        for (int i = 0; i < 4; i++) begin
            n = n + runs_t'(home[i]);
        end
        return n;
    endfunction

    assign two_outs = (outs == 2'd2);

    always_comb begin
        adv      = '0;
        outs_add = 2'd0;
        case (action)
            ACT_WALK: begin
                // Only forced runners move
                adv = {3'b000, &bases,
                       bases[2] | (&bases[1:0]),
                       bases[1] | bases[0],
                       1'b1};
            end
            ACT_SINGLE: begin
                if (two_outs) begin
                    adv = advance({bases, 1'b0}, 3'd2) | 7'b000_0001;
                end else begin
                    adv = advance({bases, 1'b1}, 3'd1);
                end
            end
            ACT_DOUBLE: begin
                if (two_outs) begin
                    adv = advance({bases, 1'b0}, 3'd3) | 7'b000_0010;  // Runner on first scores
                end else begin
                    adv = advance({bases, 1'b1}, 3'd2);
                end
            end
            ACT_TRIPLE: begin
                adv = advance({bases, 1'b1}, 3'd3);
            end
            ACT_HOME_RUN: begin
                adv = advance({bases, 1'b1}, 3'd4);
            end
            ACT_BUNT: begin
                outs_add = 2'd1;
                adv      = advance({bases, 1'b0}, 3'd1);
            end
            ACT_GROUND: begin
                // Runner on first is forced out too
                outs_add = bases[0] ? 2'd2 : 2'd1;
                adv      = advance({bases[2:1], 2'b00}, 3'd1);
            end
            ACT_FLY: begin
                outs_add = 2'd1;
                adv      = {3'b000, bases[2], 1'b0, bases[1:0]};  // Tag up from third
            end
            default: begin
                adv      = '0;
                outs_add = 2'd0;
            end
        endcase
    end

    assign outs_total = {1'b0, outs} + {1'b0, outs_add};
    assign retire     = (outs_total >= 3'd3);
    assign runs       = count_runs(adv[6:3]);

    assign play.valid        = in_valid;
    assign play.runs         = (in_valid && !retire) ? runs : runs_t'(0);
    assign play.side_retired = in_valid && retire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bases <= '0;
            outs  <= '0;
        end else if (!in_valid || retire) begin
            bases <= '0;  // Idle or new half inning
            outs  <= '0;
        end else begin
            bases <= adv[2:0];
            outs  <= outs_total[1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scoreboard_pkg.sv ====
`default_nettype none

`include "scoreboard_settings.svh"

package scoreboard_pkg;

    typedef enum logic [2:0] {
        ACT_WALK     = 3'd0,
        ACT_SINGLE   = 3'd1,
        ACT_DOUBLE   = 3'd2,
        ACT_TRIPLE   = 3'd3,
        ACT_HOME_RUN = 3'd4,
        ACT_BUNT     = 3'd5,
        ACT_GROUND   = 3'd6,
        ACT_FLY      = 3'd7
    } action_t;

    typedef logic [2:0] bases_t;  // Bit 0 first, bit 1 second, bit 2 third
    typedef logic [1:0] outs_t;
    typedef logic [2:0] runs_t;
    typedef logic [`SB_SCORE_W-1:0] score_t;

    typedef enum logic [1:0] {
        RES_GUEST_WIN = 2'd0,
        RES_HOME_WIN  = 2'd1,
        RES_DRAW      = 2'd2
    } result_t;

    typedef struct packed {
        logic  valid;
        runs_t runs;
        logic  side_retired;  // Play made the third out
    } play_result_t;

endpackage

`default_nettype wire

// ==== hdl/scoreboard_settings.svh ====
`ifndef SCOREBOARD_SETTINGS_SVH
`define SCOREBOARD_SETTINGS_SVH

// Final inning of a game
`define SB_LAST_INNING 3

// Width of each team score
`define SB_SCORE_W 8

`endif
